//--- Makefile
# Verilator build for the I/O page block, run from the project root

TOP := io_page_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f io_page.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f io_page.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation incomplete, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- io_page.f
rtl/io_bus_pkg.sv
rtl/io_dev_pkg.sv
rtl/io_page_decode.sv
rtl/switch_reg.sv
rtl/kw11l_clock.sv
rtl/reply_merge.sv
rtl/io_page_top.sv
sim/io_page_tb.sv

//--- rtl/io_bus_pkg.sv
//********************************************************************
// bus widths and transfer structs for the I/O page
// address is the full 22-bit bus address, only bits 15..1 are decoded
// byte selects are carried along, devices always write whole words
//********************************************************************

package io_bus_pkg;

   localparam int ADR_W = 22;                 // full bus address width
   localparam int DAT_W = 16;                 // data word width

   // request from the bus master, qualified by a separate strobe
   typedef struct packed {
      logic [ADR_W-1:0] adr;                  // bus address
      logic [DAT_W-1:0] dat;                  // write data
      logic             we;                   // 1 = write
      logic [1:0]       sel;                  // byte selects
   } bus_req_t;

   // one-hot device selects, strobe already folded in
   typedef struct packed {
      logic swr;                              // console switch/display 177570
      logic kw11l;                            // line clock csr 177546
   } dev_sel_t;

   // slave reply
   typedef struct packed {
      logic [DAT_W-1:0] dat;                  // read data
      logic             ack;                  // transfer acknowledge
   } reply_t;

endpackage

//--- rtl/io_dev_pkg.sv
//********************************************************************
// local device addresses and KW11-L register layout
// addresses are 16-bit I/O page offsets, bit 0 is never compared
// tick default assumes a 50 MHz clock for a 50 Hz line clock
//********************************************************************

package io_dev_pkg;

   //*****************************************************************
   // device addresses
   //*****************************************************************

   localparam logic [15:0] SWR_ADR   = 16'o177570;   // console switch/display
   localparam logic [15:0] KW11L_ADR = 16'o177546;   // line clock status

   //*****************************************************************
   // KW11-L csr bits
   //*****************************************************************

   localparam int KW11L_IE_BIT  = 6;          // interrupt enable
   localparam int KW11L_RDY_BIT = 7;          // ready / tick seen

   //*****************************************************************
   // tick generator
   //*****************************************************************

   // clocks per line clock tick, 50 MHz / 50 Hz
   localparam int unsigned TICK_DIV_DEFAULT = 1000000;

endpackage

//--- rtl/io_page_decode.sv
//********************************************************************
// I/O page address decoder for the local devices
// only address bits 15..1 are compared, the page itself is implied
// by the strobe, so selects are already strobe-qualified
//********************************************************************

`timescale 1ns/1ns

module io_page_decode (
   input  logic                               bus_stb_i,  // I/O page strobe
   input  logic [io_bus_pkg::ADR_W-1:0]       adr_i,      // request address
   output io_bus_pkg::dev_sel_t               sel_o       // device selects
);

   logic [14:0] word_adr;                     // word address within page
   logic        swr_hit;                      // address match, switch reg
   logic        kw11l_hit;                    // address match, line clock

   assign word_adr = adr_i[15:1];             // drop byte bit and upper bits

   // word compare against device addresses
   assign swr_hit   = (word_adr == io_dev_pkg::SWR_ADR[15:1]);
   assign kw11l_hit = (word_adr == io_dev_pkg::KW11L_ADR[15:1]);

   // gate with strobe so nobody downstream has to
   assign sel_o.swr   = bus_stb_i & swr_hit;
   assign sel_o.kw11l = bus_stb_i & kw11l_hit;

endmodule

//--- rtl/io_page_top.sv
//********************************************************************
// I/O page peripheral block, console switches and KW11-L clock
// master holds strobe and request until ack, then drops the strobe
// external slave reply passes straight through, no back-pressure
//********************************************************************

`timescale 1ns/1ns

module io_page_top #(
   parameter int unsigned tick_div = io_dev_pkg::TICK_DIV_DEFAULT  // clocks per tick
) (
   input  logic                               clk_p,       // system clock
   input  logic                               reset_i,     // sync reset
   input  logic                               bus_stb_i,   // I/O page strobe
   input  io_bus_pkg::bus_req_t               bus_i,       // bus request
   input  logic [io_bus_pkg::DAT_W-1:0]       ext_dat_i,   // external read data
   input  logic                               ext_ack_i,   // external ack
   input  logic [io_bus_pkg::DAT_W-1:0]       csw_i,       // console switches
   input  logic                               istb_i,      // clock vector strobe
   output logic [io_bus_pkg::DAT_W-1:0]       swr_o,       // console display
   output logic                               irq_o,       // clock interrupt
   output logic                               led_timer_o, // timer led, active low
   output io_bus_pkg::reply_t                 reply_o      // merged reply
);

   io_bus_pkg::dev_sel_t dev_sel;             // strobe-qualified selects
   io_bus_pkg::reply_t   swr_reply;           // switch register reply
   io_bus_pkg::reply_t   kw11l_reply;         // line clock reply

   //*****************************************************************
   // decode
   //*****************************************************************

   io_page_decode u_decode (
      .bus_stb_i (bus_stb_i),
      .adr_i     (bus_i.adr),
      .sel_o     (dev_sel)
   );

   //*****************************************************************
   // devices
   //*****************************************************************

   switch_reg u_swr (
      .clk_p   (clk_p),
      .reset_i (reset_i),
      .sel_i   (dev_sel.swr),
      .req_i   (bus_i),
      .csw_i   (csw_i),
      .swr_o   (swr_o),
      .reply_o (swr_reply)
   );

   kw11l_clock #(
      .tick_div (tick_div)
   ) u_kw11l (
      .clk_p       (clk_p),
      .reset_i     (reset_i),
      .sel_i       (dev_sel.kw11l),
      .req_i       (bus_i),
      .istb_i      (istb_i),
      .irq_o       (irq_o),
      .led_timer_o (led_timer_o),
      .reply_o     (kw11l_reply)
   );

   //*****************************************************************
   // reply
   //*****************************************************************

   reply_merge u_merge (
      .sel_i         (dev_sel),
      .swr_reply_i   (swr_reply),
      .kw11l_reply_i (kw11l_reply),
      .ext_dat_i     (ext_dat_i),
      .ext_ack_i     (ext_ack_i),
      .reply_o       (reply_o)
   );

endmodule

//--- rtl/kw11l_clock.sv
//********************************************************************
// KW11-L line clock, status register at 177546
// tick_div sets clocks per tick, the divider runs free from reset
// vector is fixed outside this block, istb_i only drops the request
//********************************************************************

`timescale 1ns/1ns

module kw11l_clock #(
   parameter int unsigned tick_div = io_dev_pkg::TICK_DIV_DEFAULT  // clocks per tick
) (
   input  logic                               clk_p,       // system clock
   input  logic                               reset_i,     // sync reset
   input  logic                               sel_i,       // kw11l select
   input  io_bus_pkg::bus_req_t               req_i,       // bus request
   input  logic                               istb_i,      // vector strobe
   output logic                               irq_o,       // interrupt request
   output logic                               led_timer_o, // active low, shows ie
   output io_bus_pkg::reply_t                 reply_o      // reply to merge
);

   // counter width, at least one bit
   localparam int CNT_W = (tick_div > 1) ? $clog2(tick_div) : 1;

   logic [CNT_W-1:0]               cnt_q;     // tick divider
   logic                           tick_q;    // one-cycle tick pulse
   logic                           tick_prev_q; // tick delayed, edge detect
   logic                           tick_rise; // 0->1 on tick
   logic                           ie_q;      // interrupt enable
   logic                           rdy_q;     // ready
   logic                           irq_q;     // pending request
   logic                           ack_q;     // reply register
   logic [io_bus_pkg::DAT_W-1:0]   rd_dat;    // csr read image

   //*****************************************************************
   // tick divider
   //*****************************************************************

   always_ff @(posedge clk_p) begin
      if (reset_i) begin
         cnt_q  <= '0;
         tick_q <= 1'b0;
      end else if (cnt_q == CNT_W'(tick_div - 1)) begin
         cnt_q  <= '0;                        // wrap at terminal count
         tick_q <= 1'b1;                      // pulse in next cycle
      end else begin
         cnt_q  <= cnt_q + 1'b1;
         tick_q <= 1'b0;
      end
   end

   assign tick_rise = tick_q & ~tick_prev_q;  // rising edge only

   //*****************************************************************
   // status register and interrupt request
   //*****************************************************************

   always_ff @(posedge clk_p) begin
      if (reset_i) begin
         tick_prev_q <= 1'b0;
         ie_q        <= 1'b0;
         rdy_q       <= 1'b1;                 // ready after reset
         irq_q       <= 1'b0;
      end else begin
         tick_prev_q <= tick_q;
         // bus write, whole word
         if (sel_i && req_i.we) begin
            ie_q  <= req_i.dat[io_dev_pkg::KW11L_IE_BIT];
            rdy_q <= req_i.dat[io_dev_pkg::KW11L_RDY_BIT];
         end
         // tick wins over a write to ready
         if (tick_rise) begin
            rdy_q <= 1'b1;
            if (ie_q) begin
               irq_q <= 1'b1;                 // raise request
            end
         end
         // vector taken or enable cleared drops the request
         if (irq_q && (!ie_q || istb_i)) begin
            irq_q <= 1'b0;
         end
      end
   end

   // only bits 7 and 6 are implemented
   always_comb begin
      rd_dat                            = '0;
      rd_dat[io_dev_pkg::KW11L_RDY_BIT] = rdy_q;
      rd_dat[io_dev_pkg::KW11L_IE_BIT]  = ie_q;
   end

   //*****************************************************************
   // reply
   //*****************************************************************

   always_ff @(posedge clk_p) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= sel_i & ~ack_q;             // selected, not yet acking
      end
   end

   assign reply_o.dat = rd_dat;
   assign reply_o.ack = ack_q;
   assign irq_o       = irq_q;
   assign led_timer_o = ~ie_q;                // led on while enabled

endmodule

//--- rtl/reply_merge.sv
//********************************************************************
// reply merge for local devices and the external slave
// data is a wired-OR bus, external data must be zero when idle
// no arbitration, a single slave is expected to answer
//********************************************************************

`timescale 1ns/1ns

module reply_merge (
   input  io_bus_pkg::dev_sel_t               sel_i,         // device selects
   input  io_bus_pkg::reply_t                 swr_reply_i,   // switch register
   input  io_bus_pkg::reply_t                 kw11l_reply_i, // line clock
   input  logic [io_bus_pkg::DAT_W-1:0]       ext_dat_i,     // external data
   input  logic                               ext_ack_i,     // external ack
   output io_bus_pkg::reply_t                 reply_o        // merged reply
);

   logic [io_bus_pkg::DAT_W-1:0] swr_dat;     // gated switch data
   logic [io_bus_pkg::DAT_W-1:0] kw11l_dat;   // gated csr data

   //*****************************************************************
   // data gating
   //*****************************************************************

   // local data only while its own select is up
   assign swr_dat   = sel_i.swr   ? swr_reply_i.dat   : '0;
   assign kw11l_dat = sel_i.kw11l ? kw11l_reply_i.dat : '0;

   //*****************************************************************
   // wired-OR
   //*****************************************************************

   assign reply_o.dat = ext_dat_i | swr_dat | kw11l_dat;   // ext ungated
   assign reply_o.ack = ext_ack_i | swr_reply_i.ack | kw11l_reply_i.ack;

endmodule

//--- rtl/switch_reg.sv
//********************************************************************
// console switch register (read) and display register (write)
// reads return the live switch inputs, the merge gates them by select
// ack toggles every cycle while the select is held
//********************************************************************

`timescale 1ns/1ns

module switch_reg (
   input  logic                               clk_p,      // system clock
   input  logic                               reset_i,    // sync reset
   input  logic                               sel_i,      // swr select
   input  io_bus_pkg::bus_req_t               req_i,      // bus request
   input  logic [io_bus_pkg::DAT_W-1:0]       csw_i,      // console switches
   output logic [io_bus_pkg::DAT_W-1:0]       swr_o,      // display outputs
   output io_bus_pkg::reply_t                 reply_o     // reply to merge
);

   logic ack_q;                               // reply register
   logic ack_nxt;                             // selected, not yet acked

   //*****************************************************************
   // display latch
   //*****************************************************************

   always_ff @(posedge clk_p) begin
      if (reset_i) begin
         swr_o <= '0;                         // display blank after reset
      end else if (sel_i && req_i.we) begin
         swr_o <= req_i.dat;                  // whole word, byte sel ignored
      end
   end

   //*****************************************************************
   // reply
   //*****************************************************************

   assign ack_nxt = sel_i & ~ack_q;           // one pulse per strobe edge

   always_ff @(posedge clk_p) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ack_nxt;
      end
   end

   assign reply_o.dat = csw_i;                // switches, ungated
   assign reply_o.ack = ack_q;

endmodule

//--- sim/io_page_stimulus.txt
# op f0 f1 f2 f3, fields hex. R adr csw {ext_ack,ext_dat} exp_dat | W adr dat exp_swr 0
# T cycles exp_irq 0 0 | S 0 0 0 0 | I exp_irq exp_led 0 0
# after reset
I 0 1 0 0
R 3FFF66 0000 00000 0080
# console switches and display
R 3FFF78 3C91 00000 3C91
W 3FFF78 1234 1234 0
R 3FFF78 A5C3 00000 A5C3
R 3FFF78 5E17 00000 5E17
# line clock enable, then one tick
W 3FFF66 0040 1234 0
I 0 0 0 0
R 3FFF66 9D4E 00000 0040
T 2A 1 0 0
R 3FFF66 E270 00000 00C0
I 1 0 0 0
# vector strobe drops the request
S 0 0 0 0
I 0 0 0 0
R 3FFF66 0000 00000 00C0
T 0A 1 0 0
# enable cleared, ticks set ready only
W 3FFF66 0000 1234 0
I 0 1 0 0
T 28 0 0 0
R 3FFF66 4B8D 00000 0080
T 20 0 0 0
# external slave passes through
R 3FE000 7F3A 1BEEF BEEF
R 3FE000 7F3A 02222 2222
R 3FFF76 FFFF 10000 0000
R 3FFF64 FFFF 1C0DE C0DE
R 3FE000 0000 10001 0001
# more display and switch traffic
W 3FFF78 ABCD ABCD 0
R 3FFF78 06B2 00000 06B2
W 3FFF79 00FF 00FF 0
R 3FFF79 0F0F 00000 0F0F
R 3FFF78 D318 00000 D318
W 3FFF78 FFFF FFFF 0
R 3FFF78 71E4 00000 71E4
W 3FFF78 0000 0000 0
R 3FFF78 C65A 00000 C65A
R 3FFF66 2A9F 00000 0080
I 0 1 0 0

//--- sim/io_page_tb.sv
//********************************************************************
// testbench for io_page_top with the tick divider cut to 40 clocks
// reads sim/io_page_stimulus.txt, run from the project root
// tick checks rely on the cycle count of each opcode staying fixed
//********************************************************************

`timescale 1ns/1ns

module io_page_tb;

   localparam int    CLK_HALF  = 50;          // 100 ns period
   localparam int    DRIVE_DLY = 10;          // input skew after rising edge
   localparam int    ACK_LIMIT = 4;           // cycles before giving up on ack
   localparam string STIM_FILE = "sim/io_page_stimulus.txt";

   logic                             clk_p;
   logic                             reset_i;
   logic                             bus_stb_i;
   io_bus_pkg::bus_req_t             bus_i;
   logic [io_bus_pkg::DAT_W-1:0]     ext_dat_i;
   logic                             ext_ack_i;
   logic [io_bus_pkg::DAT_W-1:0]     csw_i;
   logic                             istb_i;
   logic [io_bus_pkg::DAT_W-1:0]     swr_o;
   logic                             irq_o;
   logic                             led_timer_o;
   io_bus_pkg::reply_t               reply_o;

   int cycle_cnt   = 0;                       // clocks since start
   int cycle_limit = 200;                     // raised once the file is counted
   int check_cnt   = 0;
   int err_cnt     = 0;

   io_page_top #(.tick_div(40)) DUT (
      .clk_p       (clk_p),
      .reset_i     (reset_i),
      .bus_stb_i   (bus_stb_i),
      .bus_i       (bus_i),
      .ext_dat_i   (ext_dat_i),
      .ext_ack_i   (ext_ack_i),
      .csw_i       (csw_i),
      .istb_i      (istb_i),
      .swr_o       (swr_o),
      .irq_o       (irq_o),
      .led_timer_o (led_timer_o),
      .reply_o     (reply_o)
   );

   initial begin
      clk_p = 1'b0;
      forever #CLK_HALF clk_p = ~clk_p;
   end

   always @(posedge clk_p) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("run stopped by timeout after %0d cycles", cycle_cnt);
         $display("checks %0d, errors %0d", check_cnt, err_cnt + 1);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //*****************************************************************
   // checks
   //*****************************************************************

   task automatic compare_hex(input string sig, input logic [15:0] exp_v,
                              input logic [15:0] got_v);
      check_cnt++;
      assert (got_v == exp_v) else begin
         err_cnt++;
         $display("[FAIL] %s: expected %h, got %h", sig, exp_v, got_v);
      end
   endtask

   task automatic check_ack(input logic [21:0] adr, input logic exp_ack, input logic acked);
      check_cnt++;
      assert (acked == exp_ack) else begin
         err_cnt++;
         if (exp_ack) begin
            $display("no acknowledge from address %h within %0d cycles", adr, ACK_LIMIT);
         end else begin
            $display("unexpected acknowledge from address %h", adr);
         end
      end
   endtask

   // word address hits one of the two local devices
   function automatic logic is_local(input logic [21:0] adr);
      return (adr[15:1] == io_dev_pkg::SWR_ADR[15:1]) ||
             (adr[15:1] == io_dev_pkg::KW11L_ADR[15:1]);
   endfunction

   function automatic logic is_data_line(input string line);
      byte c;
      c = (line.len() > 0) ? line.getc(0) : 8'h00;
      return (c != 8'h00) && (c != 8'h23) && (c != 8'h0A) && (c != 8'h0D) && (c != 8'h20);
   endfunction

   //*****************************************************************
   // bus transfer, strobe held until ack then dropped for one cycle
   //*****************************************************************

   task automatic run_bus(input logic [21:0] adr, input logic [15:0] wdat, input logic we,
                          input logic [15:0] edat, input logic eack, output logic acked,
                          output int lat, output logic [15:0] rdat,
                          output logic [15:0] swr_seen);
      bus_i.adr = adr;
      bus_i.dat = wdat;
      bus_i.we  = we;
      bus_i.sel = 2'b11;                      // full word
      ext_dat_i = edat;
      ext_ack_i = eack;
      bus_stb_i = 1'b1;
      lat       = 0;
      @(negedge clk_p);                       // mid cycle, outputs settled
      while (!reply_o.ack && lat < ACK_LIMIT) begin
         @(negedge clk_p);
         lat++;
      end
      acked    = reply_o.ack;
      rdat     = reply_o.dat;
      swr_seen = swr_o;
      @(posedge clk_p);
      #DRIVE_DLY;
      bus_stb_i = 1'b0;
      bus_i.we  = 1'b0;
      ext_dat_i = '0;                         // wired-OR bus idles at zero
      ext_ack_i = 1'b0;
      @(posedge clk_p);
      #DRIVE_DLY;
   endtask

   task automatic do_read(input logic [21:0] adr, input logic [15:0] csw,
                          input logic [16:0] ext, input logic [15:0] exp_dat);
      logic        acked;
      int          lat;
      logic [15:0] rdat;
      logic [15:0] swr_seen;
      logic        local_hit;
      local_hit = is_local(adr);
      csw_i     = csw;
      run_bus(adr, 16'h0, 1'b0, ext[15:0], ext[16], acked, lat, rdat, swr_seen);
      check_ack(adr, local_hit | ext[16], acked);
      if (acked && (local_hit || ext[16])) begin
         compare_hex("reply_o.ack latency", local_hit ? 16'h1 : 16'h0, lat[15:0]);
      end
      compare_hex("reply_o.dat", exp_dat, rdat);
   endtask

   task automatic do_write(input logic [21:0] adr, input logic [15:0] wdat,
                           input logic [15:0] exp_swr);
      logic        acked;
      int          lat;
      logic [15:0] rdat;
      logic [15:0] swr_seen;
      run_bus(adr, wdat, 1'b1, 16'h0, 1'b0, acked, lat, rdat, swr_seen);
      check_ack(adr, is_local(adr), acked);
      compare_hex("swr_o", exp_swr, swr_seen);  // latched one cycle after strobe
   endtask

   task automatic wait_cycles(input int n, input logic exp_irq);
      repeat (n) @(posedge clk_p);
      @(negedge clk_p);
      compare_hex("irq_o", {15'b0, exp_irq}, {15'b0, irq_o});
      @(posedge clk_p);
      #DRIVE_DLY;
   endtask

   task automatic pulse_istb();
      istb_i = 1'b1;                          // one cycle vector strobe
      @(posedge clk_p);
      #DRIVE_DLY;
      istb_i = 1'b0;
   endtask

   task automatic idle_check(input logic exp_irq, input logic exp_led);
      @(negedge clk_p);
      compare_hex("irq_o", {15'b0, exp_irq}, {15'b0, irq_o});
      compare_hex("led_timer_o", {15'b0, exp_led}, {15'b0, led_timer_o});
      @(posedge clk_p);
      #DRIVE_DLY;
   endtask

   task automatic run_line(input string line);
      logic [7:0]  op;
      logic [31:0] f0;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      int          n;
      n = $sscanf(line, "%c %h %h %h %h", op, f0, f1, f2, f3);
      if (n != 5) begin
         err_cnt++;
         $display("malformed stimulus line: %s", line);
      end else begin
         case (op)
            8'h52:   do_read(f0[21:0], f1[15:0], f2[16:0], f3[15:0]);     // R
            8'h57:   do_write(f0[21:0], f1[15:0], f2[15:0]);              // W
            8'h54:   wait_cycles(int'(f0), f1[0]);                        // T
            8'h53:   pulse_istb();                                        // S
            8'h49:   idle_check(f0[0], f1[0]);                            // I
            default: begin
               err_cnt++;
               $display("unknown opcode in stimulus line: %s", line);
            end
         endcase
      end
   endtask

   //*****************************************************************
   // main sequence
   //*****************************************************************

   initial begin
      int    fd;
      int    data_lines;
      string line;
      reset_i    = 1'b1;
      bus_stb_i  = 1'b0;
      bus_i      = '0;
      ext_dat_i  = '0;
      ext_ack_i  = 1'b0;
      csw_i      = '0;
      istb_i     = 1'b0;
      data_lines = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         err_cnt++;
         $display("cannot open stimulus file %s", STIM_FILE);
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (is_data_line(line)) data_lines++;
         end
         $fclose(fd);
         cycle_limit = 40 * data_lines + 200;
         fd = $fopen(STIM_FILE, "r");
         repeat (2) @(posedge clk_p);         // reset for two cycles
         #DRIVE_DLY;
         reset_i = 1'b0;
         while ($fgets(line, fd) != 0) begin
            if (is_data_line(line)) run_line(line);
         end
         $fclose(fd);
      end
      $display("checks %0d, errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
